//--- hdl/regex_scan_macros.svh
`ifndef REGEX_SCAN_MACROS_SVH
`define REGEX_SCAN_MACROS_SVH

// Stream id width and the number of ids it can address
`define RS_STREAM_W 6
`define RS_NUM_STREAMS 64

// Width of a per-category packet match counter
`define RS_COUNT_W 16

// Characters in each keyword
// Matcher state runs from 0 to this value
`define RS_KEY_LEN 4

// Categories scanned in parallel
`define RS_NUM_CAT 2

`endif

//--- hdl/regex_scan_pkg.sv
`include "regex_scan_macros.svh"

package regex_scan_pkg;

  // One payload byte
  typedef logic [7:0] char_t;

  // Number of keyword characters matched so far
  typedef logic [2:0] dfa_state_t;

  typedef logic [`RS_STREAM_W-1:0] stream_id_t;
  typedef logic [`RS_COUNT_W-1:0] match_count_t;

  // Input beat, qualified by valid
  // sop and eop may both be set on a one-character packet
  typedef struct packed {
    logic       valid;
    logic       sop;
    logic       eop;
    stream_id_t stream_id;
    char_t      ch;
  } in_beat_t;

  // Control from the front end, shared by all categories
  typedef struct packed {
    logic       load_state;
    logic       new_stream;
    stream_id_t stream_id;
    logic       char_vld;
    char_t      ch;
    logic       eop;
  } cat_ctl_t;

endpackage

//--- hdl/keyword_dfa.sv
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module keyword_dfa
  import regex_scan_pkg::*;
#(
  parameter logic [31:0] KEYWORD = "imap"
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       char_vld,
  input  logic       state_vld,
  input  char_t      ch,
  input  dfa_state_t state_in,
  output dfa_state_t state_out,
  output logic       accept
);

  localparam int KEY_LEN = `RS_KEY_LEN;

  dfa_state_t state_q;
  dfa_state_t cur_state;
  dfa_state_t nxt_state;

  // Upper case letters map onto lower case, everything else passes
  function automatic char_t fold(char_t c);
    if (c >= 8'h41 && c <= 8'h5a)
    begin
      return c | 8'h20;
    end
    return c;
  endfunction

  // Keyword character idx, first character in the top byte
  function automatic char_t key_char(int idx);
    return fold(KEYWORD[(KEY_LEN-1-idx)*8 +: 8]);
  endfunction

  // Longest keyword prefix that ends the matched text plus c
  // A full match falls back through the same search
  function automatic dfa_state_t next_state(dfa_state_t s, char_t c);
    int   s_i;
    int   l;
    int   j;
    logic ok;
    dfa_state_t best;
    s_i  = int'(s);
    best = '0;
    // Shorter candidates first so the longest hit wins
    for (l = 1; l <= KEY_LEN; l++)
    begin
      if (l <= s_i + 1)
      begin
        ok = (key_char(l-1) == c);
        for (j = 0; j < KEY_LEN - 1; j++)
        begin
          if (j < l - 1 && key_char(j) != key_char(s_i - l + 1 + j))
          begin
            ok = 1'b0;
          end
        end
        if (ok)
        begin
          best = dfa_state_t'(l);
        end
      end
    end
    return best;
  endfunction

  // Restored state takes over from the held one
  assign cur_state = state_vld ? state_in : state_q;
  assign nxt_state = next_state(cur_state, fold(ch));
  assign state_out = state_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= '0;
      accept  <= 1'b0;
    end
    else
    begin
      // Hit when the whole keyword has just been seen
      accept <= char_vld && (nxt_state == dfa_state_t'(KEY_LEN));
      if (char_vld)
      begin
        state_q <= nxt_state;
      end
    end
  end

endmodule

//--- hdl/category_ctx.sv
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module category_ctx
  import regex_scan_pkg::*;
#(
  parameter logic [31:0] KEYWORD = "imap"
)
(
  input  logic         clk,
  input  logic         rst_n,
  input  cat_ctl_t     ctl,
  input  logic         enable,
  output match_count_t count,
  output logic         fired
);

  // Saved matcher state with one entry per stream id
  dfa_state_t state_mem [`RS_NUM_STREAMS];

  // Load request one cycle behind ctl
  logic       ld_q;
  logic       ld_new_q;
  stream_id_t ld_id_q;

  // Matcher input registers
  char_t      ch_r;
  dfa_state_t state_in_r;
  logic       char_vld_r;
  logic       state_vld_r;

  // Matcher outputs
  dfa_state_t state_out;
  dfa_state_t state_out_r;
  logic       accept;

  logic       pkt_match;
  logic       wr_en;
  dfa_state_t restore_state;

  // Write back only for an enabled category
  assign wr_en = ctl.eop & enable;

  // New stream starts clean
  // A write to the same id in this cycle is forwarded past the memory
  always_comb
  begin
    if (ld_new_q)
      restore_state = '0;
    else if (wr_en && ctl.stream_id == ld_id_q)
      restore_state = state_out_r;
    else
      restore_state = state_mem[ld_id_q];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ld_q        <= 1'b0;
      char_vld_r  <= 1'b0;
      state_vld_r <= 1'b0;
    end
    else
    begin
      ld_q        <= ctl.load_state;
      char_vld_r  <= ctl.char_vld;
      state_vld_r <= ld_q;
    end
  end

  // Payload side of the pipeline
  always_ff @(posedge clk)
  begin
    ld_new_q    <= ctl.new_stream;
    ld_id_q     <= ctl.stream_id;
    ch_r        <= ctl.ch;
    state_in_r  <= restore_state;
    state_out_r <= state_out;
    if (wr_en)
    begin
      state_mem[ctl.stream_id] <= state_out_r;
    end
  end

  keyword_dfa #(
    .KEYWORD (KEYWORD)
  ) u_dfa (
    .clk       (clk),
    .rst_n     (rst_n),
    .char_vld  (char_vld_r),
    .state_vld (state_vld_r),
    .ch        (ch_r),
    .state_in  (state_in_r),
    .state_out (state_out),
    .accept    (accept)
  );

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pkt_match <= 1'b0;
      count     <= '0;
      fired     <= 1'b0;
    end
    else
    begin
      // Flag drops as the restored state enters the matcher
      if (state_vld_r)
        pkt_match <= 1'b0;
      if (accept)
        pkt_match <= 1'b1;
      // One count per matching packet
      if (ctl.eop)
      begin
        fired <= enable & pkt_match;
        if (enable)
          count <= count + match_count_t'(pkt_match);
      end
    end
  end

  // Load and write-back share the stream id field
  a_no_load_at_eop: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctl.load_state && ctl.eop));

endmodule

//--- hdl/stream_frontend.sv
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module stream_frontend
  import regex_scan_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  in_beat_t in_beat,
  output cat_ctl_t ctl
);

  // Stages from the registered eop to ctl.eop
  localparam int EOP_DLY = 4;

  in_beat_t                   beat_r;
  logic [`RS_NUM_STREAMS-1:0] seen_q;
  stream_id_t                 pkt_id_q;

  // Character delay stage
  logic  chr_vld_q;
  char_t chr_q;

  // eop delay line, the stream id rides along
  logic [EOP_DLY-1:0] eop_dly_q;
  stream_id_t         eop_id_q [EOP_DLY];

  logic       load;
  stream_id_t eop_id;

  assign load = beat_r.valid & beat_r.sop;

  // One-character packet has no held id yet
  assign eop_id = beat_r.sop ? beat_r.stream_id : pkt_id_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      beat_r.valid <= 1'b0;
      beat_r.sop   <= 1'b0;
      beat_r.eop   <= 1'b0;
      seen_q       <= '0;
      chr_vld_q    <= 1'b0;
      eop_dly_q    <= '0;
    end
    else
    begin
      beat_r    <= in_beat;
      chr_vld_q <= beat_r.valid;
      eop_dly_q <= {eop_dly_q[EOP_DLY-2:0], beat_r.valid & beat_r.eop};
      // Id counts as seen once its first load goes out
      if (load)
        seen_q[beat_r.stream_id] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    chr_q       <= beat_r.ch;
    eop_id_q[0] <= eop_id;
    for (int i = 1; i < EOP_DLY; i++)
    begin
      eop_id_q[i] <= eop_id_q[i-1];
    end
    if (load)
      pkt_id_q <= beat_r.stream_id;
  end

  always_comb
  begin
    ctl.load_state = load;
    ctl.new_stream = ~seen_q[beat_r.stream_id];
    // Load id during a load, otherwise the id of the ending packet
    ctl.stream_id  = load ? beat_r.stream_id : eop_id_q[EOP_DLY-1];
    ctl.char_vld   = chr_vld_q;
    ctl.ch         = chr_q;
    ctl.eop        = eop_dly_q[EOP_DLY-1];
  end

  // Idle gap of two cycles between packets
  a_sop_gap: assert property (@(posedge clk) disable iff (!rst_n)
    (in_beat.valid && in_beat.eop) |=> !(in_beat.valid && in_beat.sop) [*2]);

endmodule

//--- hdl/regex_scan_top.sv
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module regex_scan_top
  import regex_scan_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  in_beat_t               in_beat,
  input  logic [`RS_NUM_CAT-1:0] enable,
  output logic                   done,
  output match_count_t           count0,
  output match_count_t           count1,
  output logic [`RS_NUM_CAT-1:0] fired
);

  cat_ctl_t ctl;

  stream_frontend u_frontend (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (in_beat),
    .ctl     (ctl)
  );

  // Category 0
  category_ctx #(
    .KEYWORD ("imap")
  ) u_cat_imap (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl    (ctl),
    .enable (enable[0]),
    .count  (count0),
    .fired  (fired[0])
  );

  // Category 1
  category_ctx #(
    .KEYWORD ("pop3")
  ) u_cat_pop3 (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl    (ctl),
    .enable (enable[1]),
    .count  (count1),
    .fired  (fired[1])
  );

  // Counts and fired settle one cycle after ctl.eop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      done <= 1'b0;
    else
      done <= ctl.eop;
  end

endmodule

//--- dv/regex_scan_tb.sv
`timescale 1ns/1ps
`include "regex_scan_macros.svh"

module regex_scan_tb
  import regex_scan_pkg::*;
();

  localparam int DONE_TIMEOUT = 40;
  localparam int NUM_RANDOM = 150;

  logic                   clk;
  logic                   rst_n;
  in_beat_t               in_beat;
  logic [`RS_NUM_CAT-1:0] enable;
  logic                   done;
  match_count_t           count0;
  match_count_t           count1;
  logic [`RS_NUM_CAT-1:0] fired;

  // Reference model state
  int           mstate [`RS_NUM_CAT][`RS_NUM_STREAMS];
  bit           seen_id [`RS_NUM_STREAMS];
  string        keys [`RS_NUM_CAT];
  match_count_t exp_count [`RS_NUM_CAT];
  logic [`RS_NUM_CAT-1:0] exp_fired;
  bit           started;
  logic [31:0]  lcg_state;
  byte          pkt_q [$];
  // Small alphabet so both keywords show up often
  string        alphabet;

  regex_scan_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (in_beat),
    .enable  (enable),
    .done    (done),
    .count0  (count0),
    .count1  (count1),
    .fired   (fired)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_fail(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic byte to_lower(byte c);
    if (c >= "A" && c <= "Z")
      return c + 8'd32;
    return c;
  endfunction

  // Matched prefix plus the new character, then the longest suffix
  // that is also a keyword prefix
  function automatic int match_step(int s, byte c, string kw);
    byte text [`RS_KEY_LEN+1];
    int  n;
    int  l;
    int  k;
    int  best;
    bit  ok;
    for (k = 0; k < s; k++)
      text[k] = kw[k];
    text[s] = to_lower(c);
    n = s + 1;
    best = 0;
    // Longest candidate first, first hit wins
    for (l = (n > `RS_KEY_LEN) ? `RS_KEY_LEN : n; l >= 1; l--)
    begin
      ok = 1'b1;
      for (k = 0; k < l; k++)
        if (text[n-l+k] != kw[k])
          ok = 1'b0;
      if (ok && best == 0)
        best = l;
    end
    return best;
  endfunction

  // Expected fired and counts for the packet in pkt_q
  task automatic model_packet(input int id, input logic [1:0] en);
    int cat;
    int st;
    bit hit;
    for (cat = 0; cat < `RS_NUM_CAT; cat++)
    begin
      // First use of an id starts clean
      st = seen_id[id] ? mstate[cat][id] : 0;
      hit = 1'b0;
      foreach (pkt_q[i])
      begin
        st = match_step(st, pkt_q[i], keys[cat]);
        if (st == `RS_KEY_LEN)
          hit = 1'b1;
      end
      // Disabled category keeps its saved state
      if (en[cat])
      begin
        mstate[cat][id] = st;
        if (hit)
          exp_count[cat] = exp_count[cat] + match_count_t'(1);
      end
      exp_fired[cat] = en[cat] & hit;
    end
    seen_id[id] = 1'b1;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < DONE_TIMEOUT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!done)
      stop_with_fail("Timed out waiting for done after a packet");
  endtask

  task automatic send_packet(input int id, input logic [1:0] en);
    model_packet(id, en);
    started = 1'b1;
    enable = en;
    foreach (pkt_q[i])
    begin
      in_beat.valid = 1'b1;
      in_beat.sop = (i == 0);
      in_beat.eop = (i == pkt_q.size() - 1);
      in_beat.stream_id = stream_id_t'(id);
      in_beat.ch = pkt_q[i];
      @(posedge clk);
      #2;
    end
    in_beat = '0;
    wait_done();
    // Idle gap, the done checks sample before the model moves on
    repeat (2)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_text(input int id, input logic [1:0] en, input string s);
    pkt_q.delete();
    for (int k = 0; k < s.len(); k++)
      pkt_q.push_back(s[k]);
    send_packet(id, en);
  endtask

  task automatic random_packet();
    int          id;
    int          len;
    logic [31:0] r;
    logic [1:0]  en;
    r = next_rand();
    // Few ids so streams come back often
    id = 7 * int'(r[31:16] % 6);
    len = 1 + int'(r[15:8] % 12);
    en = r[21:20];
    // Memory entry of a stream is written first by an enabled packet
    if (!seen_id[id])
      en = 2'b11;
    pkt_q.delete();
    for (int k = 0; k < len; k++)
    begin
      r = next_rand();
      pkt_q.push_back(alphabet[int'(r[18:16])]);
    end
    send_packet(id, en);
  endtask

  initial
  begin
    in_beat = '0;
    enable = '0;
    rst_n = 1'b0;
    started = 1'b0;
    exp_fired = '0;
    lcg_state = 32'h716ee523;
    alphabet = "impao3Ix";
    keys[0] = "imap";
    keys[1] = "pop3";
    for (int c = 0; c < `RS_NUM_CAT; c++)
      exp_count[c] = '0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Quiet cycles after reset
    repeat (4) @(posedge clk);
    #2;
    // Split over two packets of one stream, mixed case
    send_text(40, 2'b11, "xxIm");
    send_text(40, 2'b11, "APxx");
    // Partial match left on 41, fresh stream 42 must not finish it
    send_text(41, 2'b11, "xpo");
    send_text(42, 2'b11, "p3x");
    // Category 0 disabled on the first half
    send_text(43, 2'b11, "xxxx");
    send_text(43, 2'b10, "ima");
    send_text(43, 2'b11, "pxx");
    // Several hits in one packet count once
    send_text(44, 2'b11, "imapimapPoP3pop3");
    send_text(45, 2'b01, "PoP3imap");
    for (int p = 0; p < NUM_RANDOM; p++)
      random_packet();
    repeat (3) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

  a_idle_clean: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> (!done && count0 == '0 && count1 == '0))
    else stop_with_fail($sformatf("error at %0t ns: done or count set before any packet",
      $time));

  // done six cycles after the eop beat, and at no other time
  a_done_delay: assert property (@(posedge clk) disable iff (!rst_n)
    (in_beat.valid && in_beat.eop) |-> ##6 done)
    else stop_with_fail($sformatf("error at %0t ns: done missing after eop", $time));

  a_done_source: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(in_beat.valid && in_beat.eop, 6))
    else stop_with_fail($sformatf("error at %0t ns: done without an eop beat", $time));

  a_fired: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (fired == exp_fired))
    else stop_with_fail($sformatf("error at %0t ns: fired %b expected %b",
      $time, fired, exp_fired));

  a_counts: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (count0 == exp_count[0] && count1 == exp_count[1]))
    else stop_with_fail($sformatf("error at %0t ns: counts %0d %0d expected %0d %0d",
      $time, count0, count1, exp_count[0], exp_count[1]));

endmodule

//--- filelist.f
+incdir+hdl
hdl/regex_scan_pkg.sv
hdl/keyword_dfa.sv
hdl/category_ctx.sv
hdl/stream_frontend.sv
hdl/regex_scan_top.sv
dv/regex_scan_tb.sv

//--- Makefile
TOP = regex_scan_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
